// ==== include/riscvPipe_config.svh ====
`ifndef RISCVPIPE_CONFIG_SVH
`define RISCVPIPE_CONFIG_SVH

// Instruction memory depth in 32-bit words
`define IMEM_WORDS 256

// Data memory depth in 32-bit words
`define DMEM_WORDS 64

// Register shown at the top level (a0)
`define A0_REG 10

`endif

// ==== source/riscvPkg.sv ====
package riscvPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regIdx_t;

    // PASSB carries the U immediate for LUI
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLT   = 3'd5,
        ALU_PASSB = 3'd6
    } aluOp_t;

    typedef enum logic [1:0] {
        RES_ALU     = 2'd0,
        RES_MEM     = 2'd1,
        RES_PCPLUS4 = 2'd2
    } resultSrc_t;

    // All zero is a bubble
    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       memRead;
        logic       branch;
        logic       branchNe;
        logic       jump;
        logic       aluSrcImm;
        aluOp_t     aluOp;
        resultSrc_t resultSrc;
        logic       halt;
    } ctrl_t;

endpackage

// ==== source/pipeIf.sv ====
interface hazardIf (
    input logic clk,
    input logic rstN
);
    import riscvPkg::*;

    regIdx_t    rs1D;
    regIdx_t    rs2D;
    regIdx_t    rs1E;
    regIdx_t    rs2E;
    regIdx_t    rdE;
    regIdx_t    rdM;
    regIdx_t    rdW;
    logic       memReadE;
    logic       pcSrcE;
    logic       regWriteM;
    logic       regWriteW;
    // 2'b10 memory, 2'b01 writeback, 2'b00 register file
    logic [1:0] forwardA;
    logic [1:0] forwardB;
    logic       stall;
    logic       flushD;
    logic       flushE;

    modport hazard (
        input  clk, rstN, rs1D, rs2D, rs1E, rs2E, rdE, memReadE, pcSrcE,
        input  rdM, regWriteM, rdW, regWriteW,
        output forwardA, forwardB, stall, flushD, flushE
    );
    modport fetch (input stall, flushD, pcSrcE);
    modport decode (output rs1D, rs2D, rs1E, rs2E, rdE, memReadE, input flushE);
    modport execute (input forwardA, forwardB, output pcSrcE, rdM, regWriteM);
    modport memory (output rdW, regWriteW);
endinterface

interface writebackIf;
    import riscvPkg::*;

    logic    regWrite;
    regIdx_t rd;
    word_t   result;
    logic    halt;
    word_t   aluResultM;

    modport memory (output regWrite, rd, result, halt, aluResultM);
    modport decode (input regWrite, rd, result, halt);
    modport execute (input result, aluResultM);
endinterface

// ==== source/fetchStage.sv ====
`include "riscvPipe_config.svh"

module fetchStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            run,
    input  logic            loadEn,
    input  riscvPkg::addr_t loadAddr,
    input  riscvPkg::word_t loadData,
    input  logic            halted,
    input  riscvPkg::addr_t targetE,
    hazardIf.fetch          hazard,
    output riscvPkg::word_t instrD,
    output riscvPkg::addr_t pcD,
    output riscvPkg::addr_t pcPlus4D
);
    import riscvPkg::*;

    localparam int    imemIdxW = $clog2(`IMEM_WORDS);
    // addi x0, x0, 0
    localparam word_t nopInstr = 32'h0000_0013;

    word_t imem [`IMEM_WORDS];
    addr_t pcF;
    addr_t pcPlus4F;
    word_t instrF;

    assign pcPlus4F = pcF + 32'd4;
    assign instrF   = imem[pcF[imemIdxW+1:2]];

    // Loader addresses whole words
    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr[imemIdxW-1:0]] <= loadData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF <= '0;
        end else if (!run) begin
            pcF <= '0;
        end else if (!halted) begin
            if (hazard.pcSrcE) begin
                pcF <= targetE;
            end else if (!hazard.stall) begin
                pcF <= pcPlus4F;
            end
        end
    end

    // Redirect wins over a load-use hold
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD   <= nopInstr;
            pcD      <= '0;
            pcPlus4D <= '0;
        end else if (!run || hazard.flushD) begin
            instrD <= nopInstr;
        end else if (!hazard.stall && !halted) begin
            instrD   <= instrF;
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

    aLoadIdle: assert property (@(posedge clk) disable iff (!rstN) loadEn |-> !run)
        else $error("instruction memory written while the core runs");

endmodule

// ==== source/decodeStage.sv ====
`include "riscvPipe_config.svh"

module decodeStage (
    input  logic              clk,
    input  logic              rstN,
    input  riscvPkg::word_t   instrD,
    input  riscvPkg::addr_t   pcD,
    input  riscvPkg::addr_t   pcPlus4D,
    hazardIf.decode           hazard,
    writebackIf.decode        wb,
    output riscvPkg::ctrl_t   ctrlE,
    output riscvPkg::word_t   rd1E,
    output riscvPkg::word_t   rd2E,
    output riscvPkg::word_t   immE,
    output riscvPkg::addr_t   pcE,
    output riscvPkg::addr_t   pcPlus4E,
    output riscvPkg::regIdx_t rdE,
    output riscvPkg::word_t   a0
);
    import riscvPkg::*;

    localparam logic [6:0] opcodeR      = 7'b0110011;
    localparam logic [6:0] opcodeImm    = 7'b0010011;
    localparam logic [6:0] opcodeLui    = 7'b0110111;
    localparam logic [6:0] opcodeLoad   = 7'b0000011;
    localparam logic [6:0] opcodeStore  = 7'b0100011;
    localparam logic [6:0] opcodeBranch = 7'b1100011;
    localparam logic [6:0] opcodeJal    = 7'b1101111;
    localparam logic [6:0] opcodeSystem = 7'b1110011;

    word_t   regs [32];
    ctrl_t   ctrlD;
    word_t   immD;
    word_t   rd1D;
    word_t   rd2D;
    regIdx_t rs1D;
    regIdx_t rs2D;
    regIdx_t rdD;
    regIdx_t rs1E;
    regIdx_t rs2E;
    logic    opKnown;
    logic    wbEn;

    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];
    assign rdD  = instrD[11:7];

    always_comb begin
        ctrlD   = '0;
        immD    = {{20{instrD[31]}}, instrD[31:20]};
        case (instrD[6:0])
            opcodeR: begin
                ctrlD.regWrite = 1'b1;
                case (instrD[14:12])
                    3'b000:  ctrlD.aluOp = instrD[30] ? ALU_SUB : ALU_ADD;
                    3'b111:  ctrlD.aluOp = ALU_AND;
                    3'b110:  ctrlD.aluOp = ALU_OR;
                    3'b100:  ctrlD.aluOp = ALU_XOR;
                    3'b010:  ctrlD.aluOp = ALU_SLT;
                    default: ctrlD.regWrite = 1'b0;
                endcase
            end
            opcodeImm: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
            end
            opcodeLui: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.aluOp     = ALU_PASSB;
                immD            = {instrD[31:12], 12'b0};
            end
            opcodeLoad: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.memRead   = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.resultSrc = RES_MEM;
            end
            opcodeStore: begin
                ctrlD.memWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            end
            opcodeBranch: begin
                ctrlD.branch   = 1'b1;
                ctrlD.branchNe = instrD[12];
                immD = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25],
                        instrD[11:8], 1'b0};
            end
            opcodeJal: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.jump      = 1'b1;
                ctrlD.resultSrc = RES_PCPLUS4;
                immD = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20],
                        instrD[30:21], 1'b0};
            end
            // Only EBREAK is kept from SYSTEM
            opcodeSystem: ctrlD.halt = 1'b1;
            default: ;
        endcase
    end

    // Opcodes and R-type functions the core implements
    always_comb begin
        case (instrD[6:0])
            opcodeR: begin
                opKnown = (instrD[14:12] == 3'b000) || (instrD[14:12] == 3'b111) ||
                          (instrD[14:12] == 3'b110) || (instrD[14:12] == 3'b100) ||
                          (instrD[14:12] == 3'b010);
            end
            opcodeImm, opcodeLui, opcodeLoad, opcodeStore, opcodeBranch, opcodeJal,
            opcodeSystem: opKnown = 1'b1;
            default: opKnown = 1'b0;
        endcase
    end

    // Writes stop once the halt is in writeback
    assign wbEn = wb.regWrite && !wb.halt && (wb.rd != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Same-cycle write is bypassed to the read
    function automatic word_t readReg(input regIdx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wbEn && wb.rd == idx) begin
            return wb.result;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd1D = readReg(rs1D);
        rd2D = readReg(rs2D);
    end

    assign a0 = regs[`A0_REG];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlE <= '0;
            rdE   <= '0;
            rs1E  <= '0;
            rs2E  <= '0;
        end else begin
            ctrlE <= hazard.flushE ? ctrl_t'('0) : ctrlD;
            rdE   <= rdD;
            rs1E  <= rs1D;
            rs2E  <= rs2D;
        end
    end

    always_ff @(posedge clk) begin
        rd1E     <= rd1D;
        rd2E     <= rd2D;
        immE     <= immD;
        pcE      <= pcD;
        pcPlus4E <= pcPlus4D;
    end

    assign hazard.rs1D     = rs1D;
    assign hazard.rs2D     = rs2D;
    assign hazard.rs1E     = rs1E;
    assign hazard.rs2E     = rs2E;
    assign hazard.rdE      = rdE;
    assign hazard.memReadE = ctrlE.memRead;

    // An unknown opcode reaches execute as a bubble
    aUnknownNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        !opKnown |=> !ctrlE.regWrite)
        else $error("unknown opcode produced a register write");

endmodule

// ==== source/executeStage.sv ====
module executeStage (
    input  logic              clk,
    input  logic              rstN,
    input  riscvPkg::ctrl_t   ctrlE,
    input  riscvPkg::word_t   rd1E,
    input  riscvPkg::word_t   rd2E,
    input  riscvPkg::word_t   immE,
    input  riscvPkg::addr_t   pcE,
    input  riscvPkg::addr_t   pcPlus4E,
    input  riscvPkg::regIdx_t rdE,
    hazardIf.execute          hazard,
    writebackIf.execute       wb,
    output riscvPkg::addr_t   targetE,
    output riscvPkg::ctrl_t   ctrlM,
    output riscvPkg::word_t   aluResultM,
    output riscvPkg::word_t   writeDataM,
    output riscvPkg::word_t   pcPlus4M,
    output riscvPkg::regIdx_t rdM
);
    import riscvPkg::*;

    word_t srcA;
    word_t srcB;
    word_t writeDataE;
    word_t aluResultE;
    logic  equal;
    logic  taken;

    function automatic word_t forwardSel(input logic [1:0] sel, input word_t regVal,
                                         input word_t memVal, input word_t wbVal);
        case (sel)
            2'b10:   return memVal;
            2'b01:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA       = forwardSel(hazard.forwardA, rd1E, wb.aluResultM, wb.result);
    assign writeDataE = forwardSel(hazard.forwardB, rd2E, wb.aluResultM, wb.result);
    assign srcB       = ctrlE.aluSrcImm ? immE : writeDataE;

    always_comb begin
        case (ctrlE.aluOp)
            ALU_ADD: aluResultE = srcA + srcB;
            ALU_SUB: aluResultE = srcA - srcB;
            ALU_AND: aluResultE = srcA & srcB;
            ALU_OR:  aluResultE = srcA | srcB;
            ALU_XOR: aluResultE = srcA ^ srcB;
            ALU_SLT: aluResultE = {31'b0, $signed(srcA) < $signed(srcB)};
            default: aluResultE = srcB;
        endcase
    end

    // Branches compare the register operands, never the immediate
    assign equal         = (srcA == writeDataE);
    assign taken         = ctrlE.branch && (equal != ctrlE.branchNe);
    assign hazard.pcSrcE = ctrlE.jump || taken;
    assign targetE       = pcE + immE;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlM <= '0;
            rdM   <= '0;
        end else begin
            ctrlM <= ctrlE;
            rdM   <= rdE;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
    end

    assign hazard.rdM       = rdM;
    assign hazard.regWriteM = ctrlM.regWrite;

endmodule

// ==== source/memoryStage.sv ====
`include "riscvPipe_config.svh"

module memoryStage (
    input  logic              clk,
    input  logic              rstN,
    input  riscvPkg::ctrl_t   ctrlM,
    input  riscvPkg::word_t   aluResultM,
    input  riscvPkg::word_t   writeDataM,
    input  riscvPkg::word_t   pcPlus4M,
    input  riscvPkg::regIdx_t rdM,
    hazardIf.memory           hazard,
    writebackIf.memory        wb,
    output logic              halted
);
    import riscvPkg::*;

    localparam int dmemIdxW = $clog2(`DMEM_WORDS);

    word_t               dmem [`DMEM_WORDS];
    logic [dmemIdxW-1:0] dmemIdx;
    word_t               readDataM;
    logic                frozen;
    logic                regWriteW;
    logic                haltW;
    regIdx_t             rdW;
    resultSrc_t          resultSrcW;
    word_t               aluResultW;
    word_t               readDataW;
    word_t               pcPlus4W;
    word_t               resultW;

    assign dmemIdx   = aluResultM[dmemIdxW+1:2];
    assign readDataM = dmem[dmemIdx];
    // A store right behind EBREAK is already blocked
    assign frozen    = haltW || halted;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ctrlM.memWrite && !frozen) begin
            dmem[dmemIdx] <= writeDataM;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteW  <= 1'b0;
            haltW      <= 1'b0;
            rdW        <= '0;
            resultSrcW <= RES_ALU;
            halted     <= 1'b0;
        end else begin
            regWriteW  <= ctrlM.regWrite;
            haltW      <= ctrlM.halt;
            rdW        <= rdM;
            resultSrcW <= ctrlM.resultSrc;
            if (haltW) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        aluResultW <= aluResultM;
        readDataW  <= readDataM;
        pcPlus4W   <= pcPlus4M;
    end

    always_comb begin
        case (resultSrcW)
            RES_MEM:     resultW = readDataW;
            RES_PCPLUS4: resultW = pcPlus4W;
            default:     resultW = aluResultW;
        endcase
    end

    assign wb.regWrite = regWriteW;
    assign wb.rd       = rdW;
    assign wb.result   = resultW;
    assign wb.halt     = frozen;
    // A JAL in memory forwards its link value
    assign wb.aluResultM = (ctrlM.resultSrc == RES_PCPLUS4) ? pcPlus4M : aluResultM;

    assign hazard.rdW       = rdW;
    assign hazard.regWriteW = regWriteW;

    aWordAligned: assert property (@(posedge clk) disable iff (!rstN)
        (ctrlM.memRead || ctrlM.memWrite) |-> aluResultM[1:0] == 2'b00)
        else $error("misaligned data access");

endmodule

// ==== source/hazardUnit.sv ====
module hazardUnit (
    hazardIf.hazard hazard
);
    import riscvPkg::*;

    // Nearest producer wins
    function automatic logic [1:0] forwardFor(input regIdx_t rs,
                                              input regIdx_t rdM, input logic regWriteM,
                                              input regIdx_t rdW, input logic regWriteW);
        if (regWriteM && rdM != '0 && rdM == rs) begin
            return 2'b10;
        end
        if (regWriteW && rdW != '0 && rdW == rs) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    assign hazard.forwardA = forwardFor(hazard.rs1E, hazard.rdM, hazard.regWriteM,
                                        hazard.rdW, hazard.regWriteW);
    assign hazard.forwardB = forwardFor(hazard.rs2E, hazard.rdM, hazard.regWriteM,
                                        hazard.rdW, hazard.regWriteW);

    assign hazard.stall  = hazard.memReadE &&
                           (hazard.rdE == hazard.rs1D || hazard.rdE == hazard.rs2D);
    assign hazard.flushD = hazard.pcSrcE;
    assign hazard.flushE = hazard.pcSrcE || hazard.stall;

    // The flushed execute stage cannot hold a load right after a redirect
    aFlushFirst: assert property (@(posedge hazard.clk) disable iff (!hazard.rstN)
        hazard.pcSrcE |=> !hazard.stall)
        else $error("load-use stall raised behind a redirect");

endmodule

// ==== source/riscvPipe.sv ====
module riscvPipe (
    input  logic            clk,
    input  logic            rstN,
    input  logic            run,
    input  logic            loadEn,
    input  riscvPkg::addr_t loadAddr,
    input  riscvPkg::word_t loadData,
    output riscvPkg::word_t a0,
    output logic            halted
);
    import riscvPkg::*;

    word_t   instrD;
    addr_t   pcD;
    addr_t   pcPlus4D;
    addr_t   pcE;
    addr_t   pcPlus4E;
    addr_t   targetE;
    ctrl_t   ctrlE;
    ctrl_t   ctrlM;
    word_t   rd1E;
    word_t   rd2E;
    word_t   immE;
    word_t   aluResultM;
    word_t   writeDataM;
    word_t   pcPlus4M;
    regIdx_t rdE;
    regIdx_t rdM;

    hazardIf hazardBus (.clk(clk), .rstN(rstN));
    writebackIf wbBus ();

    fetchStage fetchStage_inst (
        .clk(clk), .rstN(rstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .halted(halted), .targetE(targetE), .hazard(hazardBus),
        .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D)
    );

    decodeStage decodeStage_inst (
        .clk(clk), .rstN(rstN), .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D),
        .hazard(hazardBus), .wb(wbBus), .ctrlE(ctrlE), .rd1E(rd1E), .rd2E(rd2E),
        .immE(immE), .pcE(pcE), .pcPlus4E(pcPlus4E), .rdE(rdE), .a0(a0)
    );

    executeStage executeStage_inst (
        .clk(clk), .rstN(rstN), .ctrlE(ctrlE), .rd1E(rd1E), .rd2E(rd2E), .immE(immE),
        .pcE(pcE), .pcPlus4E(pcPlus4E), .rdE(rdE), .hazard(hazardBus), .wb(wbBus),
        .targetE(targetE), .ctrlM(ctrlM), .aluResultM(aluResultM),
        .writeDataM(writeDataM), .pcPlus4M(pcPlus4M), .rdM(rdM)
    );

    memoryStage memoryStage_inst (
        .clk(clk), .rstN(rstN), .ctrlM(ctrlM), .aluResultM(aluResultM),
        .writeDataM(writeDataM), .pcPlus4M(pcPlus4M), .rdM(rdM),
        .hazard(hazardBus), .wb(wbBus), .halted(halted)
    );

    hazardUnit hazardUnit_inst (
        .hazard(hazardBus)
    );

endmodule

// ==== include/riscvIss.svh ====
`ifndef RISCVISS_SVH
`define RISCVISS_SVH

`include "riscvPipe_config.svh"

// Runs a program on a zeroed machine and returns a0 at EBREAK
function automatic logic [31:0] riscvIss(input logic [31:0] prog []);
    logic [31:0] regs [32];
    logic [31:0] dmem [`DMEM_WORDS];
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    foreach (regs[i]) begin
        regs[i] = '0;
    end
    foreach (dmem[i]) begin
        dmem[i] = '0;
    end
    pc = '0;
    for (int step = 0; step < 4 * `IMEM_WORDS; step++) begin
        if (pc[31:2] >= prog.size()) begin
            break;
        end
        ins    = prog[pc[31:2]];
        a      = regs[ins[19:15]];
        b      = regs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = pc + 32'd4;
        case (ins[6:0])
            7'b0110011: begin
                case (ins[14:12])
                    3'b000:  regs[ins[11:7]] = ins[30] ? a - b : a + b;
                    3'b111:  regs[ins[11:7]] = a & b;
                    3'b110:  regs[ins[11:7]] = a | b;
                    3'b100:  regs[ins[11:7]] = a ^ b;
                    3'b010:  regs[ins[11:7]] = {31'b0, $signed(a) < $signed(b)};
                    default: ;
                endcase
            end
            7'b0010011: regs[ins[11:7]] = a + immI;
            7'b0110111: regs[ins[11:7]] = {ins[31:12], 12'b0};
            7'b0000011: regs[ins[11:7]] = dmem[((a + immI) >> 2) % `DMEM_WORDS];
            7'b0100011: dmem[((a + immS) >> 2) % `DMEM_WORDS] = b;
            7'b1100011: begin
                // funct3 bit 0 selects BNE
                if ((a == b) != ins[12]) begin
                    nextPc = pc + immB;
                end
            end
            7'b1101111: begin
                regs[ins[11:7]] = pc + 32'd4;
                nextPc = pc + immJ;
            end
            7'b1110011: return regs[`A0_REG];
            default: ;
        endcase
        regs[0] = '0;
        pc = nextPc;
    end
    return regs[`A0_REG];
endfunction

`endif

// ==== sim/riscvPipeTb.sv ====
module riscvPipeTb;
    import riscvPkg::*;

    `include "riscvIss.svh"

    localparam int          timeoutCycles = 2000;
    localparam int          randomPrograms = 40;
    localparam logic [31:0] lfsrSeed = 32'hd0b6_6ed4;
    localparam word_t       ebreakInstr = 32'h0010_0073;

    logic  clk;
    logic  rstN;
    logic  run;
    logic  loadEn;
    addr_t loadAddr;
    word_t loadData;
    word_t a0;
    logic  halted;

    logic [31:0] lfsr;
    word_t       progQ [$];
    word_t       prog [];
    word_t       expectedA0;
    string       currentName;
    logic        compared;
    int          programCount;

    riscvPipe riscvPipe_inst (
        .clk(clk), .rstN(rstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .a0(a0), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int takeBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // Half of the picks land on a0
    function automatic int pickReg();
        int v;
        v = takeBits(4);
        return (v < 8) ? v : `A0_REG;
    endfunction

    function automatic word_t regOp(input int f7, input int f3, input int rd,
                                    input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic word_t lui(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t lw(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic word_t sw(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic word_t branchOp(input int ne, input int rs1, input int rs2,
                                       input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, ne[0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic word_t jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic applyReset();
        @(posedge clk);
        #2;
        rstN   = 1'b0;
        run    = 1'b0;
        loadEn = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rstN = 1'b1;
    endtask

    task automatic runProgram(input string name);
        int cycles;
        applyReset();
        assert (halted === 1'b0)
            else reportFailure($sformatf("error halted got %h expected 0 after reset", halted));
        assert (a0 === 32'h0)
            else reportFailure($sformatf("error a0 got %h expected 00000000 after reset", a0));
        prog = new[progQ.size()];
        foreach (progQ[i]) begin
            prog[i] = progQ[i];
        end
        expectedA0  = riscvIss(prog);
        currentName = name;
        foreach (prog[i]) begin
            @(posedge clk);
            #2;
            loadEn   = 1'b1;
            loadAddr = i;
            loadData = prog[i];
        end
        @(posedge clk);
        #2;
        loadEn   = 1'b0;
        compared = 1'b0;
        run      = 1'b1;
        cycles   = 0;
        while (!compared && cycles < timeoutCycles) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        assert (compared)
            else reportFailure($sformatf("program %s did not halt within %0d cycles",
                                         name, timeoutCycles));
    endtask

    // Forward branches and jumps only, so every program reaches its EBREAK
    task automatic buildRandomProgram();
        int len;
        int kind;
        int sel;
        int skip;
        progQ.delete();
        len = 2 + takeBits(6) % 39;
        for (int i = 0; i < len - 1; i++) begin
            kind = takeBits(4);
            if (kind < 5) begin
                sel = takeBits(3) % 6;
                case (sel)
                    0:       progQ.push_back(regOp(0, 0, pickReg(), pickReg(), pickReg()));
                    1:       progQ.push_back(regOp(32, 0, pickReg(), pickReg(), pickReg()));
                    2:       progQ.push_back(regOp(0, 7, pickReg(), pickReg(), pickReg()));
                    3:       progQ.push_back(regOp(0, 6, pickReg(), pickReg(), pickReg()));
                    4:       progQ.push_back(regOp(0, 4, pickReg(), pickReg(), pickReg()));
                    default: progQ.push_back(regOp(0, 2, pickReg(), pickReg(), pickReg()));
                endcase
            end else if (kind < 8) begin
                progQ.push_back(addi(pickReg(), pickReg(), takeBits(12)));
            end else if (kind == 8) begin
                progQ.push_back(lui(pickReg(), takeBits(20)));
            end else if (kind < 11) begin
                progQ.push_back(lw(pickReg(), 0, takeBits(6) * 4));
            end else if (kind < 13) begin
                progQ.push_back(sw(pickReg(), 0, takeBits(6) * 4));
            end else begin
                skip = 1 + takeBits(6) % (len - 1 - i);
                if (kind < 15) begin
                    progQ.push_back(branchOp(takeBits(1), pickReg(), pickReg(), skip * 4));
                end else begin
                    progQ.push_back(jal(pickReg(), skip * 4));
                end
            end
        end
        progQ.push_back(ebreakInstr);
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rstN && run && halted && !compared) begin
            assert (a0 === expectedA0)
                else reportFailure($sformatf("error a0 got %h expected %h in %s",
                                             a0, expectedA0, currentName));
            compared = 1'b1;
            programCount++;
        end
    end

    initial begin
        rstN         = 1'b0;
        run          = 1'b0;
        loadEn       = 1'b0;
        loadAddr     = '0;
        loadData     = '0;
        lfsr         = lfsrSeed;
        compared     = 1'b1;
        programCount = 0;

        progQ.delete();
        progQ.push_back(ebreakInstr);
        runProgram("ebreak only");

        // Memory and writeback forwarding chains
        progQ.delete();
        progQ.push_back(lui(1, 'h12345));
        progQ.push_back(addi(1, 1, 'h678));
        progQ.push_back(addi(2, 1, 1));
        progQ.push_back(regOp(0, 0, 3, 1, 2));
        progQ.push_back(regOp(32, 0, 4, 3, 1));
        progQ.push_back(regOp(0, 4, 5, 4, 3));
        progQ.push_back(regOp(0, 6, 6, 5, 1));
        progQ.push_back(regOp(0, 7, 7, 6, 3));
        progQ.push_back(addi(9, 0, -5));
        progQ.push_back(regOp(0, 2, 8, 9, 7));
        progQ.push_back(regOp(0, 0, 10, 7, 8));
        progQ.push_back(regOp(0, 0, 10, 10, 6));
        progQ.push_back(ebreakInstr);
        runProgram("forwarding chain");

        // Load-use stalls and store then load
        progQ.delete();
        progQ.push_back(addi(1, 0, 'h55));
        progQ.push_back(sw(1, 0, 8));
        progQ.push_back(lw(2, 0, 8));
        progQ.push_back(regOp(0, 0, 10, 2, 2));
        progQ.push_back(lw(3, 0, 8));
        progQ.push_back(regOp(32, 0, 10, 10, 3));
        progQ.push_back(lui(4, 'habcde));
        progQ.push_back(sw(4, 0, 252));
        progQ.push_back(lw(5, 0, 252));
        progQ.push_back(regOp(0, 4, 10, 5, 10));
        progQ.push_back(lw(6, 0, 0));
        progQ.push_back(regOp(0, 0, 10, 10, 6));
        progQ.push_back(ebreakInstr);
        runProgram("load store");

        progQ.delete();
        progQ.push_back(addi(1, 0, 3));
        progQ.push_back(addi(2, 0, 3));
        progQ.push_back(branchOp(0, 1, 2, 8));
        progQ.push_back(addi(10, 10, 100));
        progQ.push_back(addi(10, 10, 1));
        progQ.push_back(branchOp(1, 1, 2, 8));
        progQ.push_back(addi(10, 10, 2));
        progQ.push_back(branchOp(1, 1, 0, 12));
        progQ.push_back(addi(10, 10, 200));
        progQ.push_back(addi(10, 10, 300));
        progQ.push_back(branchOp(0, 1, 0, 8));
        progQ.push_back(addi(10, 10, 4));
        progQ.push_back(jal(5, 8));
        progQ.push_back(addi(10, 10, 500));
        progQ.push_back(regOp(0, 0, 10, 10, 5));
        progQ.push_back(ebreakInstr);
        runProgram("branches");

        // Link value lands in a0
        progQ.delete();
        progQ.push_back(addi(10, 0, 9));
        progQ.push_back(addi(1, 0, 1));
        progQ.push_back(jal(10, 12));
        progQ.push_back(addi(10, 0, 1));
        progQ.push_back(addi(10, 0, 2));
        progQ.push_back(ebreakInstr);
        runProgram("jal link");

        for (int p = 0; p < randomPrograms; p++) begin
            buildRandomProgram();
            runProgram($sformatf("random %0d", p));
        end

        if (programCount == randomPrograms + 5) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== riscvPipe.f ====
+incdir+include
source/riscvPkg.sv
source/pipeIf.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/riscvPipe.sv
sim/riscvPipeTb.sv
